//--- c2c_monitor_top.f
rtl/c2c_pkg.sv
rtl/c2c_replica_counter.sv
rtl/c2c_vote.sv
rtl/c2c_margin_calc.sv
rtl/c2c_monitor_site.sv
rtl/c2c_stream_arbiter.sv
rtl/c2c_monitor_top.sv
dv/c2c_monitor_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the C2C monitor

VERILATOR ?= verilator
TB_TOP    ?= c2c_monitor_tb
RTL_TOP   ?= c2c_monitor_top
FLIST     ?= c2c_monitor_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LFLAGS    ?= --lint-only -Wall --timing

SRCS := $(wildcard rtl/*.sv dv/*.sv)
SIM  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

run: build
	./$(SIM) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/c2c_monitor_tb.sv
// Testbench for the C2C monitor: clock, reset, LCG stimulus, reference model and assertions
`timescale 1ns/10ps
`default_nettype none

module c2c_monitor_tb
  import c2c_pkg::*;
();

  logic                                 i_clk = 1'b0;
  logic                                 i_rst_n;
  logic                                 i_enable;
  logic [N_SITES-1:0][N_REPL-1:0][1:0]  i_sense;
  c2c_vote_opt_e                        i_vote;
  logic [SCALE_WD-1:0]                  i_scale;
  logic [1:0][COEF_A_WD-1:0]            i_coef_a;
  logic [1:0][COEF_BC_WD-1:0]           i_coef_b;
  logic [1:0][COEF_BC_WD-1:0]           i_coef_c;
  logic [1:0][COEF_D_WD-1:0]            i_coef_d;
  logic                                 o_valid;
  logic [DATA_WD-1:0]                   o_data;
  logic [SITE_WD-1:0]                   o_site;
  logic                                 i_ready;

  logic [31:0]        lcg_state = 32'd89022;
  int                 duty [N_SITES][N_REPL][2];
  int                 frame = 0;
  logic [DATA_WD-1:0] exp_data [N_SITES];
  int                 delivered [N_SITES];
  int                 err_cnt = 0;
  int                 test_cnt = 0;
  int                 fail_cnt = 0;
  logic               ever_enabled = 1'b0;
  logic               timeout_hit = 1'b0;
  string              timeout_what;

  // Scoreboard state
  logic [N_SITES-1:0]              site_valid;
  logic [N_SITES-1:0]              site_ready;
  logic [N_SITES-1:0]              site_hs;
  int                              in_flight;
  logic [SITE_WD-1:0]              last_gnt;
  logic [N_SITES-1:0][N_SITES-1:0] seen;                // Site g served while w waited
  logic                            unfair;

  always #50 i_clk = ~i_clk;

  c2c_monitor_top u_c2c_monitor_top (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_enable (i_enable),
    .i_sense  (i_sense),
    .i_vote   (i_vote),
    .i_scale  (i_scale),
    .i_coef_a (i_coef_a),
    .i_coef_b (i_coef_b),
    .i_coef_c (i_coef_c),
    .i_coef_d (i_coef_d),
    .o_valid  (o_valid),
    .o_data   (o_data),
    .o_site   (o_site),
    .i_ready  (i_ready)
  );

  // ==================================================
  // Stimulus helpers and reference model
  // ==================================================

  function automatic logic [15:0] rand_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic int middle_of_three(input int a, input int b, input int c);
    int hi;
    int lo;
    hi = (a > b) ? a : b;
    hi = (hi > c) ? hi : c;
    lo = (a < b) ? a : b;
    lo = (lo < c) ? lo : c;
    return a + b + c - hi - lo;
  endfunction

  function automatic logic [DATA_WD-1:0] expected_sample(input int s);
    int cnt [N_REPL][2];
    int pair [2];
    int m [2];
    int lo;
    for (int r = 0; r < N_REPL; r++) begin
      for (int b = 0; b < 2; b++) cnt[r][b] = 8 * duty[s][r][b];   // j high cycles per frame
    end
    for (int b = 0; b < 2; b++) begin
      if (i_vote == vote_median) pair[b] = middle_of_three(cnt[0][b], cnt[1][b], cnt[2][b]);
      else                       pair[b] = cnt[int'(i_vote)][b];
    end
    for (int k = 0; k < 2; k++) begin
      m[k] = int'(i_coef_a[k]) * pair[LVT] * pair[SVT] + int'(i_coef_b[k]) * pair[SVT]
           + int'(i_coef_c[k]) * pair[LVT] + int'(i_coef_d[k]);
    end
    lo = (m[0] < m[1]) ? m[0] : m[1];
    return DATA_WD'(lo >> i_scale);
  endfunction

  task automatic step();
    @(posedge i_clk);
    #1;
  endtask

  task automatic hit_timeout(input string what);
    timeout_what = what;
    timeout_hit  = 1'b1;
    forever @(posedge i_clk);
  endtask

  // Distinct duties per replica so every vote choice is visible
  task automatic randomize_duties();
    for (int s = 0; s < N_SITES; s++) begin
      for (int b = 0; b < 2; b++) begin
        duty[s][0][b] = int'(rand_word() % 16'd9);
        do duty[s][1][b] = int'(rand_word() % 16'd9);
        while (duty[s][1][b] == duty[s][0][b]);
        do duty[s][2][b] = int'(rand_word() % 16'd9);
        while (duty[s][2][b] == duty[s][0][b] || duty[s][2][b] == duty[s][1][b]);
      end
    end
  endtask

  task automatic randomize_coefs();
    for (int k = 0; k < 2; k++) begin
      i_coef_a[k] = COEF_A_WD'(rand_word());
      i_coef_b[k] = COEF_BC_WD'(rand_word());
      i_coef_c[k] = COEF_BC_WD'(rand_word());
      i_coef_d[k] = rand_word() >> 1;
    end
    i_scale = SCALE_WD'(rand_word() % 16'd16);
  endtask

  task automatic drain();
    int idle;
    int cyc;
    idle = 0;
    cyc  = 0;
    while (idle < 10) begin
      step();
      idle = o_valid ? 0 : idle + 1;
      cyc++;
      if (cyc > 300) hit_timeout("drain after disable");
    end
  endtask

  task automatic run_phase(input string name, input int n_per_site, input bit backpressure);
    int          base [N_SITES];
    int          errs_before;
    int          cyc;
    bit          done;
    logic [15:0] rnd;
    errs_before = err_cnt;
    for (int s = 0; s < N_SITES; s++) begin
      exp_data[s] = expected_sample(s);
      base[s]     = delivered[s];
    end
    step();
    i_enable     = 1'b1;
    ever_enabled = 1'b1;
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      step();
      if (backpressure) begin
        rnd     = rand_word();
        i_ready = ((cyc % 250) < 100) && rnd[7];     // Long stalls let a served site return
      end else begin
        i_ready = 1'b1;
      end
      done = 1'b1;
      for (int s = 0; s < N_SITES; s++) begin
        if (delivered[s] - base[s] < n_per_site) done = 1'b0;
      end
      cyc++;
      if (!done && cyc > 3000) hit_timeout(name);
    end
    i_enable = 1'b0;
    i_ready  = 1'b1;
    drain();
    test_cnt++;
    if (err_cnt != errs_before) fail_cnt++;
    $display("%-14s done, %0d failed checks", name, err_cnt - errs_before);
  endtask

  // ==================================================
  // Sensor drive and scoreboard
  // ==================================================

  always @(posedge i_clk) begin
    #1;
    frame = (frame + 1) % 8;
    for (int s = 0; s < N_SITES; s++) begin
      for (int r = 0; r < N_REPL; r++) begin
        for (int b = 0; b < 2; b++) i_sense[s][r][b] = (frame < duty[s][r][b]);
      end
    end
  end

  assign site_valid = u_c2c_monitor_top.site_valid;
  assign site_ready = u_c2c_monitor_top.site_ready;
  assign site_hs    = site_valid & site_ready;

  always @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      in_flight <= 0;
      last_gnt  <= '0;
      seen      <= '0;
      for (int s = 0; s < N_SITES; s++) delivered[s] <= 0;
    end else begin
      in_flight <= in_flight + int'(|site_hs) - int'(o_valid && i_ready);
      for (int s = 0; s < N_SITES; s++) begin
        if (site_hs[s]) last_gnt <= SITE_WD'(s);
      end
      if (o_valid && i_ready) delivered[o_site] <= delivered[o_site] + 1;
      for (int w = 0; w < N_SITES; w++) begin
        for (int g = 0; g < N_SITES; g++) begin
          if (!site_valid[w] || site_ready[w]) seen[w][g] <= 1'b0;
          else if (site_ready[g])              seen[w][g] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    unfair = 1'b0;
    for (int w = 0; w < N_SITES; w++) begin
      for (int g = 0; g < N_SITES; g++) begin
        if (site_valid[w] && site_ready[g] && seen[w][g]) unfair = 1'b1;
      end
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  a_idle_quiet : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !ever_enabled |-> !o_valid)
    else begin
      err_cnt++;
      $display("Error at %0t: output valid before the monitor was enabled", $time);
    end

  a_data : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_valid |-> (o_site < SITE_WD'(N_SITES)) && (o_data == exp_data[o_site]))
    else begin
      err_cnt++;
      $display("Mismatch at %0t: site %0d data %h, expected %h",
               $time, o_site, o_data, exp_data[o_site]);
    end

  a_tag : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_valid |-> o_site == last_gnt)
    else begin
      err_cnt++;
      $display("Mismatch at %0t: site tag %0d, last granted site %0d", $time, o_site, last_gnt);
    end

  a_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data) && $stable(o_site))
    else begin
      err_cnt++;
      $display("Error at %0t: output changed while stalled", $time);
    end

  a_no_loss : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    in_flight == int'(o_valid))
    else begin
      err_cnt++;
      $display("Error at %0t: sample lost or duplicated, %0d in flight", $time, in_flight);
    end

  a_fair : assert property (@(posedge i_clk) disable iff (!i_rst_n) !unfair)
    else begin
      err_cnt++;
      $display("Error at %0t: site served twice while another site waited", $time);
    end

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    @(posedge timeout_hit);
    $display("Timeout: %s did not finish in time", timeout_what);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int errs_before;
    i_rst_n  = 1'b0;
    i_enable = 1'b0;
    i_sense  = '0;
    i_vote   = vote_median;
    i_scale  = '0;
    i_coef_a = '0;
    i_coef_b = '0;
    i_coef_c = '0;
    i_coef_d = '0;
    i_ready  = 1'b1;
    for (int s = 0; s < N_SITES; s++) begin
      exp_data[s]  = '0;
      for (int r = 0; r < N_REPL; r++) begin
        duty[s][r][0] = 0;
        duty[s][r][1] = 0;
      end
    end
    repeat (16) @(posedge i_clk);
    #1 i_rst_n = 1'b1;

    errs_before = err_cnt;
    repeat (20) step();                                // Idle with enable low
    test_cnt++;
    if (err_cnt != errs_before) fail_cnt++;
    $display("%-14s done, %0d failed checks", "idle", err_cnt - errs_before);

    for (int i = 0; i < 2; i++) begin
      step();
      i_vote = vote_median;
      randomize_duties();
      randomize_coefs();
      run_phase($sformatf("median_%0d", i), 3, 1'b0);
    end

    for (int v = 0; v < 3; v++) begin
      step();
      i_vote = c2c_vote_opt_e'(v);
      randomize_duties();
      randomize_coefs();
      run_phase($sformatf("fixed_repl_%0d", v), 3, 1'b0);
    end

    // Corner 0 smaller, then corner 1 smaller, then free random
    for (int i = 0; i < 4; i++) begin
      step();
      i_vote = vote_median;
      randomize_duties();
      randomize_coefs();
      if (i < 2) begin
        i_coef_a[1 - i] = i_coef_a[i];
        i_coef_b[1 - i] = i_coef_b[i];
        i_coef_c[1 - i] = i_coef_c[i];
        i_coef_d[1 - i] = i_coef_d[i] + 16'd100;
      end
      if (i == 0) i_scale = '0;                        // Truncation to DATA_WD
      run_phase($sformatf("corner_min_%0d", i), 2, 1'b0);
    end

    for (int i = 0; i < 2; i++) begin
      step();
      i_vote = vote_median;
      randomize_duties();
      randomize_coefs();
      run_phase($sformatf("backpressure_%0d", i), 6, 1'b1);
    end

    $display("Tests run %0d, tests with failures %0d, failed checks %0d",
             test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/c2c_monitor_top.sv
// Top level of the C2C monitor: sensor site array and round-robin output arbiter
`timescale 1ns/10ps
`default_nettype none

module c2c_monitor_top
  import c2c_pkg::*;
(
  input  wire                                    i_clk,
  input  wire                                    i_rst_n,
  input  logic                                   i_enable,
  input  logic [N_SITES-1:0][N_REPL-1:0][1:0]    i_sense,
  input  c2c_vote_opt_e                          i_vote,
  input  logic [SCALE_WD-1:0]                    i_scale,
  input  logic [1:0][COEF_A_WD-1:0]              i_coef_a,
  input  logic [1:0][COEF_BC_WD-1:0]             i_coef_b,
  input  logic [1:0][COEF_BC_WD-1:0]             i_coef_c,
  input  logic [1:0][COEF_D_WD-1:0]              i_coef_d,
  output logic                                   o_valid,
  output logic [DATA_WD-1:0]                     o_data,
  output logic [SITE_WD-1:0]                     o_site,
  input  logic                                   i_ready
);

  logic [N_SITES-1:0]              site_valid;
  logic [N_SITES-1:0][DATA_WD-1:0] site_data;
  logic [N_SITES-1:0]              site_ready;

  for (genvar s = 0; s < N_SITES; s++) begin : g_site
    c2c_monitor_site u_site (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_enable (i_enable),
      .i_sense  (i_sense[s]),
      .i_vote   (i_vote),
      .i_coef_a (i_coef_a),
      .i_coef_b (i_coef_b),
      .i_coef_c (i_coef_c),
      .i_coef_d (i_coef_d),
      .i_scale  (i_scale),
      .o_valid  (site_valid[s]),
      .o_data   (site_data[s]),
      .i_ready  (site_ready[s])
    );
  end

  c2c_stream_arbiter u_arbiter (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (site_valid),
    .i_data  (site_data),
    .o_ready (site_ready),
    .o_valid (o_valid),
    .o_data  (o_data),
    .o_site  (o_site),
    .i_ready (i_ready)
  );

endmodule

`default_nettype wire

//--- rtl/c2c_stream_arbiter.sv
// Round-robin valid/ready arbiter of site samples with a registered, site-tagged output
`timescale 1ns/10ps
`default_nettype none

module c2c_stream_arbiter
  import c2c_pkg::*;
(
  input  wire                               i_clk,
  input  wire                               i_rst_n,
  input  logic [N_SITES-1:0]                i_valid,
  input  logic [N_SITES-1:0][DATA_WD-1:0]   i_data,
  output logic [N_SITES-1:0]                o_ready,
  output logic                              o_valid,
  output logic [DATA_WD-1:0]                o_data,
  output logic [SITE_WD-1:0]                o_site,
  input  logic                              i_ready
);

  logic [SITE_WD-1:0] ptr_q;                           // First site to consider
  logic [SITE_WD-1:0] gnt;
  logic               found;
  logic               load;

  // Lowest requester at or after the pointer
  always_comb begin
    int idx;
    gnt   = '0;
    found = 1'b0;
    for (int i = 0; i < N_SITES; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= N_SITES) idx = idx - N_SITES;
      if (!found && i_valid[idx]) begin
        found = 1'b1;
        gnt   = SITE_WD'(idx);
      end
    end
  end

  assign load = found && (!o_valid || i_ready);

  always_comb begin
    o_ready = '0;
    if (load) o_ready[gnt] = 1'b1;
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
      ptr_q   <= '0;
    end else if (load) begin
      o_valid <= 1'b1;
      ptr_q   <= (gnt == SITE_WD'(N_SITES - 1)) ? '0 : gnt + SITE_WD'(1);
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      o_data <= i_data[gnt];
      o_site <= gnt;
    end
  end

  // Back-to-back grant moves past the last site when another one waits
  a_grant_rotates : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    load && o_valid && ((i_valid & ~(N_SITES'(1) << o_site)) != '0) |-> gnt != o_site);

  a_out_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data) && $stable(o_site));

endmodule

`default_nettype wire

//--- rtl/c2c_monitor_site.sv
// One sensor site: window sequencer, three replica counters, vote, margin and held sample
`timescale 1ns/10ps
`default_nettype none

module c2c_monitor_site
  import c2c_pkg::*;
(
  input  wire                          i_clk,
  input  wire                          i_rst_n,
  input  logic                         i_enable,
  input  logic [N_REPL-1:0][1:0]       i_sense,
  input  c2c_vote_opt_e                i_vote,
  input  logic [1:0][COEF_A_WD-1:0]    i_coef_a,
  input  logic [1:0][COEF_BC_WD-1:0]   i_coef_b,
  input  logic [1:0][COEF_BC_WD-1:0]   i_coef_c,
  input  logic [1:0][COEF_D_WD-1:0]    i_coef_d,
  input  logic [SCALE_WD-1:0]          i_scale,
  output logic                         o_valid,
  output logic [DATA_WD-1:0]           o_data,
  input  logic                         i_ready
);

  logic [STATE_WD-1:0]                  state_q;
  logic [STATE_WD-1:0]                  state_d;
  logic                                 start;
  logic                                 abort;
  logic [N_REPL-1:0]                    repl_done;
  logic                                 all_done;
  logic [N_REPL-1:0][1:0][COUNT_WD-1:0] repl_count;
  logic                                 vote_valid;
  logic [1:0][COUNT_WD-1:0]             vote_pair;
  logic                                 calc_valid;
  logic [DATA_WD-1:0]                   calc_data;

  // ==================================================
  // Window sequencer
  // ==================================================

  always_comb begin
    state_d = state_q;
    start   = 1'b0;
    abort   = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (i_enable) begin
          start   = 1'b1;
          state_d = ST_MEASURE;
        end
      end
      ST_MEASURE: begin
        if (!i_enable) begin
          abort   = 1'b1;                              // Window dropped, no sample
          state_d = ST_IDLE;
        end else if (all_done) begin
          state_d = ST_COMPUTE;
        end
      end
      ST_COMPUTE: if (calc_valid) state_d = ST_HOLD;
      ST_HOLD:    if (i_ready) state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) state_q <= ST_IDLE;
    else          state_q <= state_d;
  end

  // ==================================================
  // Datapath
  // ==================================================

  for (genvar r = 0; r < N_REPL; r++) begin : g_repl
    c2c_replica_counter u_counter (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_start (start),
      .i_abort (abort),
      .i_sense (i_sense[r]),
      .o_count (repl_count[r]),
      .o_done  (repl_done[r])
    );
  end

  assign all_done = &repl_done;                        // Replicas share one window

  c2c_vote u_vote (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (all_done),
    .i_counts (repl_count),
    .i_vote   (i_vote),
    .o_valid  (vote_valid),
    .o_pair   (vote_pair)
  );

  c2c_margin_calc u_margin_calc (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (vote_valid),
    .i_pair   (vote_pair),
    .i_coef_a (i_coef_a),
    .i_coef_b (i_coef_b),
    .i_coef_c (i_coef_c),
    .i_coef_d (i_coef_d),
    .i_scale  (i_scale),
    .o_valid  (calc_valid),
    .o_data   (calc_data)
  );

  always_ff @(posedge i_clk) begin
    if (calc_valid) o_data <= calc_data;
  end

  assign o_valid = (state_q == ST_HOLD);

  a_hold_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

`default_nettype wire

//--- rtl/c2c_margin_calc.sv
// Two-stage pipelined two-corner margin polynomial with minimum and right-shift scaling
`timescale 1ns/10ps
`default_nettype none

module c2c_margin_calc
  import c2c_pkg::*;
(
  input  wire                          i_clk,
  input  wire                          i_rst_n,
  input  logic                         i_valid,
  input  logic [1:0][COUNT_WD-1:0]     i_pair,
  input  logic [1:0][COEF_A_WD-1:0]    i_coef_a,
  input  logic [1:0][COEF_BC_WD-1:0]   i_coef_b,
  input  logic [1:0][COEF_BC_WD-1:0]   i_coef_c,
  input  logic [1:0][COEF_D_WD-1:0]    i_coef_d,
  input  logic [SCALE_WD-1:0]          i_scale,
  output logic                         o_valid,
  output logic [DATA_WD-1:0]           o_data
);

  logic [1:0][PROD_A_WD-1:0]  prod_a_d;
  logic [1:0][PROD_BC_WD-1:0] prod_b_d;
  logic [1:0][PROD_BC_WD-1:0] prod_c_d;
  logic [1:0][PROD_A_WD-1:0]  prod_a_q;
  logic [1:0][PROD_BC_WD-1:0] prod_b_q;
  logic [1:0][PROD_BC_WD-1:0] prod_c_q;
  logic                       valid1_q;
  logic [1:0][MARGIN_WD-1:0]  margin;
  logic [MARGIN_WD-1:0]       min_margin;

  // ==================================================
  // Stage 1: products per corner
  // ==================================================

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      prod_a_d[k] = i_coef_a[k] * i_pair[LVT] * i_pair[SVT];
      prod_b_d[k] = i_coef_b[k] * i_pair[SVT];
      prod_c_d[k] = i_coef_c[k] * i_pair[LVT];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      prod_a_q <= prod_a_d;
      prod_b_q <= prod_b_d;
      prod_c_q <= prod_c_d;
    end
  end

  // ==================================================
  // Stage 2: sum, minimum and scaling
  // ==================================================

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      margin[k] = MARGIN_WD'(prod_a_q[k]) + MARGIN_WD'(prod_b_q[k])
                + MARGIN_WD'(prod_c_q[k]) + MARGIN_WD'(i_coef_d[k]);
    end
  end

  assign min_margin = (margin[1] < margin[0]) ? margin[1] : margin[0];

  always_ff @(posedge i_clk) begin
    if (valid1_q) o_data <= DATA_WD'(min_margin >> i_scale);   // Truncated
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid1_q <= 1'b0;
      o_valid  <= 1'b0;
    end else begin
      valid1_q <= i_valid;
      o_valid  <= valid1_q;
    end
  end

endmodule

`default_nettype wire

//--- rtl/c2c_vote.sv
// Median-of-three or fixed-replica selection of count pairs, registered with its valid
`timescale 1ns/10ps
`default_nettype none

module c2c_vote
  import c2c_pkg::*;
(
  input  wire                                  i_clk,
  input  wire                                  i_rst_n,
  input  logic                                 i_valid,
  input  logic [N_REPL-1:0][1:0][COUNT_WD-1:0] i_counts,
  input  c2c_vote_opt_e                        i_vote,
  output logic                                 o_valid,
  output logic [1:0][COUNT_WD-1:0]             o_pair
);

  logic [1:0][COUNT_WD-1:0] median;
  logic [1:0][COUNT_WD-1:0] sel;

  function automatic logic [COUNT_WD-1:0] median3(
    input logic [COUNT_WD-1:0] a,
    input logic [COUNT_WD-1:0] b,
    input logic [COUNT_WD-1:0] c
  );
    logic [COUNT_WD-1:0] lo;
    logic [COUNT_WD-1:0] hi;
    lo = (a < b) ? a : b;
    hi = (a < b) ? b : a;
    if (c < lo)      return lo;
    else if (c > hi) return hi;
    else             return c;
  endfunction

  // SVT and LVT voted separately
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      median[k] = median3(i_counts[0][k], i_counts[1][k], i_counts[2][k]);
    end
  end

  always_comb begin
    case (i_vote)
      vote_repl_0: sel = i_counts[0];
      vote_repl_1: sel = i_counts[1];
      vote_repl_2: sel = i_counts[2];
      default:     sel = median;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) o_valid <= 1'b0;
    else          o_valid <= i_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) o_pair <= sel;
  end

  // Vote option must not move while a result is taken
  a_vote_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |-> $stable(i_vote));

endmodule

`default_nettype wire

//--- rtl/c2c_replica_counter.sv
// High-cycle counter for one SVT and one LVT sensor input over a measurement window
`timescale 1ns/10ps
`default_nettype none

module c2c_replica_counter
  import c2c_pkg::*;
(
  input  wire                       i_clk,
  input  wire                       i_rst_n,
  input  logic                      i_start,
  input  logic                      i_abort,
  input  logic [1:0]                i_sense,
  output logic [1:0][COUNT_WD-1:0]  o_count,
  output logic                      o_done
);

  logic                      active_q;
  logic [CYC_WD-1:0]         cyc_q;
  logic                      last_cyc;
  logic [1:0][COUNT_WD-1:0]  cnt_q;
  logic [1:0][COUNT_WD-1:0]  cnt_d;

  assign last_cyc = (cyc_q == CYC_WD'(WINDOW_CYCLES - 1));

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      active_q <= 1'b0;
      cyc_q    <= '0;
    end else if (i_abort) begin
      active_q <= 1'b0;
    end else if (i_start) begin
      active_q <= 1'b1;
      cyc_q    <= '0;
    end else if (active_q) begin
      active_q <= !last_cyc;
      cyc_q    <= cyc_q + CYC_WD'(1);
    end
  end

  // Running totals include the current cycle
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      cnt_d[b] = cnt_q[b] + COUNT_WD'(active_q & i_sense[b]);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start)       cnt_q <= '0;
    else if (active_q) cnt_q <= cnt_d;
  end

  assign o_count = cnt_d;                              // Final on the last window cycle
  assign o_done  = active_q & last_cyc & !i_abort;

endmodule

`default_nettype wire

//--- rtl/c2c_pkg.sv
// Widths, window length, site count, FSM encodings and vote-option enum for the C2C monitor
`default_nettype none

package c2c_pkg;

  // ==================================================
  // Array sizes
  // ==================================================

  localparam int N_SITES = 3;                 // Peer sensor sites
  localparam int N_REPL  = 3;                 // Replicas per site
  localparam int SITE_WD = 2;                 // Site tag on the output stream

  // ==================================================
  // Measurement window
  // ==================================================

  localparam int WINDOW_CYCLES = 64;
  localparam int CYC_WD        = $clog2(WINDOW_CYCLES);
  localparam int COUNT_WD      = 7;           // 0 to 64

  // Index of each count within a pair
  localparam int SVT = 0;
  localparam int LVT = 1;

  // ==================================================
  // Margin polynomial
  // ==================================================

  localparam int COEF_A_WD  = 8;
  localparam int COEF_BC_WD = 10;
  localparam int COEF_D_WD  = 16;

  // Product widths of the three polynomial terms
  localparam int PROD_A_WD  = COEF_A_WD + 2 * COUNT_WD;
  localparam int PROD_BC_WD = COEF_BC_WD + COUNT_WD;

  localparam int MARGIN_WD = 24;              // Largest term sum fits
  localparam int DATA_WD   = 16;
  localparam int SCALE_WD  = 4;

  // ==================================================
  // Site sequencer states
  // ==================================================

  localparam int STATE_WD = 2;

  localparam logic [STATE_WD-1:0] ST_IDLE    = 2'd0;
  localparam logic [STATE_WD-1:0] ST_MEASURE = 2'd1;
  localparam logic [STATE_WD-1:0] ST_COMPUTE = 2'd2;
  localparam logic [STATE_WD-1:0] ST_HOLD    = 2'd3;

  // Replica selection
  typedef enum logic [1:0] {
    vote_repl_0 = 2'd0,
    vote_repl_1 = 2'd1,
    vote_repl_2 = 2'd2,
    vote_median = 2'd3
  } c2c_vote_opt_e;

endpackage

`default_nettype wire
